/* chip8_pkg.sv */
// ======================================================================
// CHIP-8 core package
// Shared widths, instruction word views, operation and PC action codes
// ======================================================================
package chip8_pkg;

    // Basic widths of the machine
    localparam int ADDR_W = 12;
    localparam int BYTE_W = 8;
    localparam int IDX_W  = 4;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [IDX_W-1:0]  reg_idx_t;

    // VF doubles as the flag register
    localparam reg_idx_t REG_VF = 4'd15;

    // Programs load at 0x200
    localparam addr_t PC_RESET = 12'h200;
    localparam addr_t PC_STEP  = 12'd2;

    // Opcode nibble plus a 12-bit address (0nnn, 1nnn, 2nnn, Annn, Bnnn)
    typedef struct packed {
        logic [3:0] opc;
        addr_t      nnn;
    } instr_addr_t;

    // Opcode nibble, register and immediate byte (3xkk, 6xkk, Fx1E)
    typedef struct packed {
        logic [3:0] opc;
        reg_idx_t   x;
        byte_t      kk;
    } instr_imm_t;

    // Opcode nibble, two registers and a sub-op nibble (5xy0, 8xyn)
    typedef struct packed {
        logic [3:0] opc;
        reg_idx_t   x;
        reg_idx_t   y;
        logic [3:0] n;
    } instr_reg_t;

    // One 16-bit word read through whichever view the opcode needs
    typedef union packed {
        instr_addr_t addr;
        instr_imm_t  imm;
        instr_reg_t  regs;
    } instr_t;

    // Kept operations, dropped opcodes map to OP_NOP
    typedef enum logic [4:0] {
        OP_NOP, OP_SYS, OP_RET, OP_JP, OP_CALL,
        OP_SE_IMM, OP_SNE_IMM, OP_SE_REG, OP_SNE_REG,
        OP_LD_IMM, OP_ADD_IMM,
        OP_LD_REG, OP_OR, OP_AND, OP_XOR,
        OP_ADD_REG, OP_SUB, OP_SHR, OP_SUBN, OP_SHL,
        OP_LD_I, OP_JP_V0, OP_ADD_I
    } op_t;

    // What the PC unit does on writeback
    typedef enum logic [2:0] {
        PC_INC, PC_SKIP, PC_JUMP, PC_CALL, PC_RET
    } pc_act_t;

endpackage

/* dec_ex_if.sv */
// ======================================================================
// Decode to execute channel
// Decoded operation, raw word and register operands
// ======================================================================
interface dec_ex_if;
    import chip8_pkg::*;

    // 1-cycle pulse qualifying everything below
    logic   valid;
    op_t    op;
    instr_t word;
    // Operands sampled in the decode cycle
    byte_t  vx;
    byte_t  vy;
    byte_t  v0;

    modport source (
        output valid,
        output op,
        output word,
        output vx,
        output vy,
        output v0
    );

    modport sink (
        input valid,
        input op,
        input word,
        input vx,
        input vy,
        input v0
    );

endinterface

/* ex_wb_if.sv */
// ======================================================================
// Execute to writeback channel
// Register results and the PC action of one instruction
// ======================================================================
interface ex_wb_if;
    import chip8_pkg::*;

    logic     valid;
    // Vx result
    logic     write_vx;
    reg_idx_t x;
    byte_t    vx_new;
    // VF result for the flag operations
    logic     write_vf;
    byte_t    vf_new;
    // PC update
    pc_act_t  act;
    addr_t    target;

    modport source (
        output valid, write_vx, x, vx_new, write_vf, vf_new, act, target
    );

    modport sink (
        input valid, write_vx, x, vx_new, write_vf, vf_new, act, target
    );

endinterface

/* chip8_regfile.sv */
// ======================================================================
// CHIP-8 V register file
// Sixteen 8-bit registers, two read ports plus V0, Vx and VF writes
// ======================================================================
module chip8_regfile (
    input  logic               clk,
    input  logic               arst_n,
    input  chip8_pkg::reg_idx_t rd_x,
    input  chip8_pkg::reg_idx_t rd_y,
    output chip8_pkg::byte_t   vx,
    output chip8_pkg::byte_t   vy,
    output chip8_pkg::byte_t   v0,
    input  logic               wr_en,
    input  chip8_pkg::reg_idx_t wr_x,
    input  chip8_pkg::byte_t   wr_data,
    input  logic               wr_flag_en,
    input  chip8_pkg::byte_t   wr_flag
);
    import chip8_pkg::*;

    byte_t regs [16];

    // All sixteen registers clear on reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr_en) begin
                regs[wr_x] <= wr_data;
            end
            // Later assignment wins so the flag beats Vx when x is F
            if (wr_flag_en) begin
                regs[REG_VF] <= wr_flag;
            end
        end
    end

    // Combinational reads
    assign vx = regs[rd_x];
    assign vy = regs[rd_y];
    // V0 always visible for Bnnn
    assign v0 = regs[0];

endmodule

/* chip8_fetch.sv */
// ======================================================================
// CHIP-8 fetch unit
// Program counter, return stack and the fetch strobe every fourth cycle
// ======================================================================
module chip8_fetch #(
    parameter int STACK_DEPTH = 16
) (
    input  logic             clk,
    input  logic             arst_n,
    output logic             fetch,
    output chip8_pkg::addr_t pc,
    ex_wb_if.sink            wb
);
    import chip8_pkg::*;

    localparam int SP_W = (STACK_DEPTH > 1) ? $clog2(STACK_DEPTH) : 1;
    // A skip jumps over one whole instruction
    localparam addr_t SKIP_STEP = addr_t'(2 * PC_STEP);

    logic [1:0]      phase;
    logic [SP_W-1:0] sp;
    logic [SP_W-1:0] sp_inc;
    logic [SP_W-1:0] sp_dec;
    addr_t           stack [STACK_DEPTH];

    // Pointer wraps at STACK_DEPTH in both directions
    assign sp_inc = (sp == SP_W'(STACK_DEPTH - 1)) ? '0 : sp + 1'b1;
    assign sp_dec = (sp == '0) ? SP_W'(STACK_DEPTH - 1) : sp - 1'b1;

    // Phase 3 means the next cycle is a fetch cycle
    // Starts at 3 so the first strobe follows reset release
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase <= 2'd3;
            fetch <= 1'b0;
        end else begin
            phase <= phase + 2'd1;
            fetch <= (phase == 2'd3);
        end
    end

    // PC and stack pointer follow the writeback action
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= PC_RESET;
            sp <= '0;
        end else if (wb.valid) begin
            case (wb.act)
                PC_INC:  pc <= pc + PC_STEP;
                PC_SKIP: pc <= pc + SKIP_STEP;
                PC_JUMP: pc <= wb.target;
                PC_CALL: begin
                    pc <= wb.target;
                    sp <= sp_inc;
                end
                PC_RET: begin
                    // Resume after the call instruction
                    pc <= stack[sp_dec] + PC_STEP;
                    sp <= sp_dec;
                end
                default: pc <= pc + PC_STEP;
            endcase
        end
    end

    // Stack entries hold the address of the call itself
    always_ff @(posedge clk) begin
        if (wb.valid && wb.act == PC_CALL) begin
            stack[sp] <= pc;
        end
    end

endmodule

/* chip8_decode.sv */
// ======================================================================
// CHIP-8 decode stage
// Captures the fetched word, classifies it and reads its operands
// ======================================================================
module chip8_decode (
    input  logic                clk,
    input  logic                arst_n,
    input  chip8_pkg::instr_t   instr,
    input  logic                fetch,
    output chip8_pkg::reg_idx_t rd_x,
    output chip8_pkg::reg_idx_t rd_y,
    input  chip8_pkg::byte_t    vx,
    input  chip8_pkg::byte_t    vy,
    input  chip8_pkg::byte_t    v0,
    dec_ex_if.source            de
);
    import chip8_pkg::*;

    logic fetch_d;

    // Map a word onto the kept operations
    function automatic op_t classify(instr_t w);
        op_t op;
        op = OP_NOP;
        case (w.addr.opc)
            4'h0: begin
                if (w.addr.nnn == 12'h0EE)      op = OP_RET;
                else if (w.addr.nnn != 12'h0E0) op = OP_SYS;
            end
            4'h1: op = OP_JP;
            4'h2: op = OP_CALL;
            4'h3: op = OP_SE_IMM;
            4'h4: op = OP_SNE_IMM;
            4'h5: if (w.regs.n == 4'h0) op = OP_SE_REG;
            4'h6: op = OP_LD_IMM;
            4'h7: op = OP_ADD_IMM;
            4'h8: begin
                case (w.regs.n)
                    4'h0: op = OP_LD_REG;
                    4'h1: op = OP_OR;
                    4'h2: op = OP_AND;
                    4'h3: op = OP_XOR;
                    4'h4: op = OP_ADD_REG;
                    4'h5: op = OP_SUB;
                    4'h6: op = OP_SHR;
                    4'h7: op = OP_SUBN;
                    4'hE: op = OP_SHL;
                    default: op = OP_NOP;
                endcase
            end
            4'h9: if (w.regs.n == 4'h0) op = OP_SNE_REG;
            4'hA: op = OP_LD_I;
            4'hB: op = OP_JP_V0;
            // Only Fx1E survives in the F group
            4'hF: if (w.imm.kk == 8'h1E) op = OP_ADD_I;
            default: op = OP_NOP;
        endcase
        return op;
    endfunction

    // Register addresses straight from the incoming word
    assign rd_x = instr.regs.x;
    assign rd_y = instr.regs.y;

    // instr is valid the cycle after the fetch strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_d  <= 1'b0;
            de.valid <= 1'b0;
        end else begin
            fetch_d  <= fetch;
            de.valid <= fetch_d;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_d) begin
            de.word <= instr;
            de.op   <= classify(instr);
            de.vx   <= vx;
            de.vy   <= vy;
            de.v0   <= v0;
        end
    end

endmodule

/* chip8_execute.sv */
// ======================================================================
// CHIP-8 execute stage
// ALU and flag, skip tests, jump targets and the I register
// ======================================================================
module chip8_execute (
    input  logic             clk,
    input  logic             arst_n,
    dec_ex_if.sink           de,
    ex_wb_if.source          ew,
    output chip8_pkg::addr_t i_reg
);
    import chip8_pkg::*;

    logic [8:0] sum;
    byte_t      diff_xy;
    byte_t      diff_yx;
    logic       write_vx;
    byte_t      vx_new;
    logic       write_vf;
    byte_t      vf_new;
    pc_act_t    act;
    addr_t      target;

    // Nine bits keep the carry of 8xy4
    assign sum     = {1'b0, de.vx} + {1'b0, de.vy};
    assign diff_xy = de.vx - de.vy;
    assign diff_yx = de.vy - de.vx;

    always_comb begin
        write_vx = 1'b0;
        vx_new   = de.vx;
        write_vf = 1'b0;
        vf_new   = '0;
        act      = PC_INC;
        target   = de.word.addr.nnn;
        case (de.op)
            OP_SYS, OP_JP: act = PC_JUMP;
            OP_CALL:       act = PC_CALL;
            OP_RET:        act = PC_RET;
            // Wraps modulo 4096 like any address
            OP_JP_V0: begin
                act    = PC_JUMP;
                target = de.word.addr.nnn + addr_t'(de.v0);
            end
            // Skip tests
            OP_SE_IMM:  if (de.vx == de.word.imm.kk) act = PC_SKIP;
            OP_SNE_IMM: if (de.vx != de.word.imm.kk) act = PC_SKIP;
            OP_SE_REG:  if (de.vx == de.vy) act = PC_SKIP;
            OP_SNE_REG: if (de.vx != de.vy) act = PC_SKIP;
            // Loads and plain logic
            OP_LD_IMM:  {write_vx, vx_new} = {1'b1, de.word.imm.kk};
            OP_ADD_IMM: {write_vx, vx_new} = {1'b1, de.vx + de.word.imm.kk};
            OP_LD_REG:  {write_vx, vx_new} = {1'b1, de.vy};
            OP_OR:      {write_vx, vx_new} = {1'b1, de.vx | de.vy};
            OP_AND:     {write_vx, vx_new} = {1'b1, de.vx & de.vy};
            OP_XOR:     {write_vx, vx_new} = {1'b1, de.vx ^ de.vy};
            // Flag operations also write VF
            OP_ADD_REG: begin
                {write_vx, vx_new} = {1'b1, sum[7:0]};
                {write_vf, vf_new} = {1'b1, 7'd0, sum[8]};
            end
            OP_SUB: begin
                // Strictly greater, so equal operands clear VF
                {write_vx, vx_new} = {1'b1, diff_xy};
                {write_vf, vf_new} = {1'b1, 7'd0, de.vx > de.vy};
            end
            OP_SUBN: begin
                {write_vx, vx_new} = {1'b1, diff_yx};
                {write_vf, vf_new} = {1'b1, 7'd0, de.vy > de.vx};
            end
            OP_SHR: begin
                {write_vx, vx_new} = {1'b1, 1'b0, de.vx[7:1]};
                {write_vf, vf_new} = {1'b1, 7'd0, de.vx[0]};
            end
            OP_SHL: begin
                {write_vx, vx_new} = {1'b1, de.vx[6:0], 1'b0};
                {write_vf, vf_new} = {1'b1, 7'd0, de.vx[7]};
            end
            default: act = PC_INC;
        endcase
    end

    // Control and I register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ew.valid <= 1'b0;
            i_reg    <= '0;
        end else begin
            ew.valid <= de.valid;
            if (de.valid && de.op == OP_LD_I) begin
                i_reg <= de.word.addr.nnn;
            end else if (de.valid && de.op == OP_ADD_I) begin
                // Fx1E wraps inside the 12-bit space
                i_reg <= i_reg + addr_t'(de.vx);
            end
        end
    end

    // Result fields captured with each decoded instruction
    always_ff @(posedge clk) begin
        if (de.valid) begin
            ew.write_vx <= write_vx;
            ew.x        <= de.word.regs.x;
            ew.vx_new   <= vx_new;
            ew.write_vf <= write_vf;
            ew.vf_new   <= vf_new;
            ew.act      <= act;
            ew.target   <= target;
        end
    end

endmodule

/* chip8_cpu.sv */
// ======================================================================
// CHIP-8 processor core
// Fetch, decode, execute and writeback around the V register file
// ======================================================================
module chip8_cpu #(
    parameter int STACK_DEPTH = 16
) (
    input  logic                clk,
    input  logic                arst_n,
    // Program memory request
    output logic                fetch,
    output chip8_pkg::addr_t    pc,
    input  logic [15:0]         instr,
    // Register writes
    output logic                wb_valid,
    output chip8_pkg::reg_idx_t wb_x,
    output chip8_pkg::byte_t    wb_vx,
    output logic                wb_flag_valid,
    output chip8_pkg::byte_t    wb_vf,
    output chip8_pkg::addr_t    i_reg
);
    import chip8_pkg::*;

    reg_idx_t rd_x;
    reg_idx_t rd_y;
    byte_t    rd_vx;
    byte_t    rd_vy;
    byte_t    rd_v0;

    dec_ex_if u_de_if ();
    ex_wb_if  u_ew_if ();

    // Writeback strobes double as the register file write enables
    assign wb_valid      = u_ew_if.valid & u_ew_if.write_vx;
    assign wb_x          = u_ew_if.x;
    assign wb_vx         = u_ew_if.vx_new;
    assign wb_flag_valid = u_ew_if.valid & u_ew_if.write_vf;
    assign wb_vf         = u_ew_if.vf_new;

    chip8_regfile u_regfile (
        .clk        (clk),
        .arst_n     (arst_n),
        .rd_x       (rd_x),
        .rd_y       (rd_y),
        .vx         (rd_vx),
        .vy         (rd_vy),
        .v0         (rd_v0),
        .wr_en      (wb_valid),
        .wr_x       (wb_x),
        .wr_data    (wb_vx),
        .wr_flag_en (wb_flag_valid),
        .wr_flag    (wb_vf)
    );

    chip8_fetch #(
        .STACK_DEPTH (STACK_DEPTH)
    ) u_fetch (
        .clk    (clk),
        .arst_n (arst_n),
        .fetch  (fetch),
        .pc     (pc),
        .wb     (u_ew_if.sink)
    );

    chip8_decode u_decode (
        .clk    (clk),
        .arst_n (arst_n),
        .instr  (instr),
        .fetch  (fetch),
        .rd_x   (rd_x),
        .rd_y   (rd_y),
        .vx     (rd_vx),
        .vy     (rd_vy),
        .v0     (rd_v0),
        .de     (u_de_if.source)
    );

    chip8_execute u_execute (
        .clk    (clk),
        .arst_n (arst_n),
        .de     (u_de_if.sink),
        .ew     (u_ew_if.source),
        .i_reg  (i_reg)
    );

endmodule

/* tb_chip8.sv */
// ======================================================================
// CHIP-8 core testbench
// Program memory model, reference instruction model and result checks
// ======================================================================
module tb_chip8;
    timeunit 1ns;
    timeprecision 1ps;
    import chip8_pkg::*;

    localparam int FETCH_TIMEOUT = 16;
    localparam int MAX_STEPS     = 400;
    localparam int RANDOM_COUNT  = 40;

    // Fixed sequence at 0x200: ALU and flags, skips, dropped opcodes, I loads
    localparam logic [15:0] MAIN_CODE [48] = '{
        16'h6005, 16'h61FA, 16'h7110, 16'h6233, 16'h8210, 16'h8201, 16'h8212, 16'h8203,
        16'h6AF0, 16'h6B20, 16'h8AB4, 16'h8AB5, 16'h8BA5, 16'h8AB7, 16'h8A06, 16'h8A0E,
        16'h6A10, 16'h8AA5, 16'h6FC8, 16'h6E40, 16'h8FE4, 16'h6F81, 16'h8FE6, 16'h8FFE,
        16'h3005, 16'h60FF, 16'h3006, 16'h4006, 16'h61FF, 16'h4005, 16'h6505, 16'h5050,
        16'h62FF, 16'h9050, 16'h6606, 16'h9060, 16'h63FF, 16'h5060, 16'hD123, 16'h00E0,
        16'hC0FF, 16'hF007, 16'hE19E, 16'hF155, 16'hA123, 16'hF01E, 16'hF11E, 16'h1300
    };

    logic        clk;
    logic        arst_n;
    logic        fetch;
    addr_t       pc;
    logic [15:0] instr;
    logic        wb_valid;
    reg_idx_t    wb_x;
    byte_t       wb_vx;
    logic        wb_flag_valid;
    byte_t       wb_vf;
    addr_t       i_reg;

    logic [7:0]  mem [4096];
    addr_t       asm_ptr;
    logic [31:0] lcg_state;

    // Software copy of the machine
    addr_t       ref_pc;
    addr_t       ref_i;
    byte_t       ref_v [16];
    addr_t       ref_stack [16];
    int          ref_sp;
    // Writes expected from the current instruction
    logic        exp_vx_en;
    logic        exp_vf_en;
    reg_idx_t    exp_x;
    byte_t       exp_vx;
    byte_t       exp_vf;

    chip8_cpu #(
        .STACK_DEPTH (16)
    ) dut (
        .clk           (clk),
        .arst_n        (arst_n),
        .fetch         (fetch),
        .pc            (pc),
        .instr         (instr),
        .wb_valid      (wb_valid),
        .wb_x          (wb_x),
        .wb_vx         (wb_vx),
        .wb_flag_valid (wb_flag_valid),
        .wb_vf         (wb_vf),
        .i_reg         (i_reg)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    task automatic check_pc(input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("[FAIL] pc = 0x%h, expected 0x%h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t got_x, input byte_t got_v,
                             input reg_idx_t exp_idx, input byte_t exp_v);
        if (got_x !== exp_idx || got_v !== exp_v) begin
            $display("[FAIL] %s: V%h = 0x%h, expected V%h = 0x%h",
                     name, got_x, got_v, exp_idx, exp_v);
            abort_run();
        end
    endtask

    task automatic check_i(input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("[FAIL] i_reg = 0x%h, expected 0x%h", got, exp);
            abort_run();
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Random load, add or 8xyn ALU word
    function automatic logic [15:0] random_alu();
        logic [31:0] r;
        logic [3:0]  sel;
        logic [3:0]  n;
        r   = lcg_next();
        sel = r[31:28] % 4'd9;
        n   = (sel == 4'd8) ? 4'hE : sel;
        case (r[26:25])
            2'd0:    return {4'h6, r[19:16], r[15:8]};
            2'd1:    return {4'h7, r[19:16], r[15:8]};
            default: return {4'h8, r[19:16], r[23:20], n};
        endcase
    endfunction

    task automatic emit(input logic [15:0] w);
        mem[asm_ptr]         = w[15:8];
        mem[asm_ptr + 12'd1] = w[7:0];
        asm_ptr              = asm_ptr + 12'd2;
    endtask

    // One instruction of the CHIP-8 set on the software copy
    function automatic void ref_step(input logic [15:0] w);
        reg_idx_t   x;
        reg_idx_t   y;
        logic [3:0] n;
        byte_t      kk;
        addr_t      nnn;
        byte_t      vx;
        byte_t      vy;
        addr_t      next;
        logic [8:0] s;
        x = w[11:8];
        y = w[7:4];
        n = w[3:0];
        kk = w[7:0];
        nnn = w[11:0];
        vx = ref_v[x];
        vy = ref_v[y];
        s = {1'b0, vx} + {1'b0, vy};
        next = ref_pc + 12'd2;
        exp_vx_en = 1'b0;
        exp_vf_en = 1'b0;
        exp_x = x;
        exp_vx = '0;
        exp_vf = '0;
        case (w[15:12])
            4'h0: begin
                if (nnn == 12'h0EE) begin
                    ref_sp = (ref_sp + 15) % 16;
                    next   = ref_stack[ref_sp] + 12'd2;
                end else if (nnn != 12'h0E0) begin
                    next = nnn;
                end
            end
            4'h1: next = nnn;
            4'h2: begin
                ref_stack[ref_sp] = ref_pc;
                ref_sp = (ref_sp + 1) % 16;
                next = nnn;
            end
            4'h3: if (vx == kk) next = ref_pc + 12'd4;
            4'h4: if (vx != kk) next = ref_pc + 12'd4;
            4'h5: if (n == 4'h0 && vx == vy) next = ref_pc + 12'd4;
            4'h9: if (n == 4'h0 && vx != vy) next = ref_pc + 12'd4;
            4'h6: {exp_vx_en, exp_vx} = {1'b1, kk};
            4'h7: {exp_vx_en, exp_vx} = {1'b1, vx + kk};
            4'h8: begin
                case (n)
                    4'h0: {exp_vx_en, exp_vx} = {1'b1, vy};
                    4'h1: {exp_vx_en, exp_vx} = {1'b1, vx | vy};
                    4'h2: {exp_vx_en, exp_vx} = {1'b1, vx & vy};
                    4'h3: {exp_vx_en, exp_vx} = {1'b1, vx ^ vy};
                    4'h4: begin
                        {exp_vx_en, exp_vx} = {1'b1, s[7:0]};
                        {exp_vf_en, exp_vf} = {1'b1, 7'd0, s[8]};
                    end
                    4'h5: begin
                        {exp_vx_en, exp_vx} = {1'b1, vx - vy};
                        {exp_vf_en, exp_vf} = {1'b1, 7'd0, vx > vy};
                    end
                    4'h6: begin
                        {exp_vx_en, exp_vx} = {1'b1, vx >> 1};
                        {exp_vf_en, exp_vf} = {1'b1, 7'd0, vx[0]};
                    end
                    4'h7: begin
                        {exp_vx_en, exp_vx} = {1'b1, vy - vx};
                        {exp_vf_en, exp_vf} = {1'b1, 7'd0, vy > vx};
                    end
                    4'hE: begin
                        {exp_vx_en, exp_vx} = {1'b1, vx << 1};
                        {exp_vf_en, exp_vf} = {1'b1, 7'd0, vx[7]};
                    end
                    default: ;
                endcase
            end
            4'hA: ref_i = nnn;
            4'hB: next = nnn + {4'h0, ref_v[0]};
            4'hF: if (kk == 8'h1E) ref_i = ref_i + {4'h0, vx};
            default: ;
        endcase
        // Flag write lands last so VF keeps the flag when x is F
        if (exp_vx_en) ref_v[x] = exp_vx;
        if (exp_vf_en) ref_v[15] = exp_vf;
        ref_pc = next;
    endfunction

    // Checks write pulses until the next fetch, returns the cycle count
    task automatic collect_writes(output int gap);
        logic seen_vx;
        logic seen_vf;
        seen_vx = 1'b0;
        seen_vf = 1'b0;
        gap = 0;
        do begin
            @(negedge clk);
            gap++;
            if (gap > FETCH_TIMEOUT) begin
                report_problem("Timed out waiting for the next fetch pulse");
            end
            if (wb_valid) begin
                if (!exp_vx_en) begin
                    report_problem("Vx was written by an instruction that has no Vx result");
                end
                check_reg("wb_vx", wb_x, wb_vx, exp_x, exp_vx);
                seen_vx = 1'b1;
            end
            if (wb_flag_valid) begin
                if (!exp_vf_en) begin
                    report_problem("VF was written by an instruction that sets no flag");
                end
                check_reg("wb_vf", 4'hF, wb_vf, 4'hF, exp_vf);
                seen_vf = 1'b1;
            end
        end while (!fetch);
        if (exp_vx_en && !seen_vx) report_problem("The expected Vx write never came");
        if (exp_vf_en && !seen_vf) report_problem("The expected VF write never came");
    endtask

    // Stimulus: program image, reset, then the memory answering fetches
    initial begin : stimulus
        addr_t halt_addr;
        arst_n     = 1'b0;
        instr      = '0;
        lcg_state  = 32'd22676;
        for (int a = 0; a < 4096; a++) begin
            mem[a] = 8'(a ^ (a >> 4));
        end
        asm_ptr = 12'h200;
        foreach (MAIN_CODE[k]) begin
            emit(MAIN_CODE[k]);
        end
        // Bnnn lands on 0x314 with V0 at 4
        asm_ptr = 12'h300;
        emit(16'h6004);
        emit(16'hB310);
        asm_ptr = 12'h314;
        emit(16'h2400);
        for (int k = 0; k < RANDOM_COUNT; k++) begin
            emit(random_alu());
        end
        // Final loop jumps to itself
        halt_addr = asm_ptr;
        emit({4'h1, halt_addr});
        // Calls nested three deep
        asm_ptr = 12'h400;
        emit(16'h6C11);
        emit(16'h2500);
        emit(16'h00EE);
        asm_ptr = 12'h500;
        emit(16'h6D22);
        emit(16'h2600);
        emit(16'h00EE);
        asm_ptr = 12'h600;
        emit(16'h6E33);
        emit(16'h00EE);
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        forever begin
            @(negedge clk);
            if (fetch) instr = {mem[pc], mem[pc + 12'd1]};
        end
    end

    initial begin : scoreboard
        int          gap;
        int          steps;
        int          halts;
        int          wait_cycles;
        logic [15:0] word;
        ref_pc = 12'h200;
        ref_i  = '0;
        ref_sp = 0;
        for (int r = 0; r < 16; r++) begin
            ref_v[r] = '0;
        end
        wait_cycles = 0;
        do begin
            @(negedge clk);
            wait_cycles++;
            if (wait_cycles > 2 * FETCH_TIMEOUT) begin
                report_problem("Timed out waiting for the first fetch after reset");
            end
        end while (!fetch);
        check_pc(pc, ref_pc);
        steps = 0;
        halts = 0;
        while (halts < 2 && steps < MAX_STEPS) begin
            word = {mem[ref_pc], mem[ref_pc + 12'd1]};
            if (word == {4'h1, ref_pc}) halts++;
            ref_step(word);
            collect_writes(gap);
            if (gap != 4) begin
                report_problem($sformatf("Fetch pulses came %0d cycles apart instead of 4", gap));
            end
            check_pc(pc, ref_pc);
            check_i(i_reg, ref_i);
            steps++;
        end
        if (halts < 2) report_problem("The program never reached its final loop");
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* sim.f */
chip8_pkg.sv
dec_ex_if.sv
ex_wb_if.sv
chip8_regfile.sv
chip8_fetch.sv
chip8_decode.sv
chip8_execute.sv
chip8_cpu.sv
tb_chip8.sv

/* Makefile */
# Verilator build for the CHIP-8 core and its testbench

TOP := tb_chip8

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --top-module $(TOP) -f sim.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
